//--- bench/heapCases.svh
/*
  Case table of the heap testbench with one addCase call per transfer.
  Columns are name, opcode, array, index, operand, check kind, expected data
  and expected error. Arithmetic rows get a random operand from the bench.
*/

task automatic loadCases;
  // ------------------------------------------------------------------------
  // Allocation, element access and sizes
  // ------------------------------------------------------------------------
  addCase("read never allocated", opRead, 3, 0, 16'h0000, errorOnly, 16'h0000, errNotAllocated);
  addCase("alloc first", opAlloc, 0, 0, 16'h0000, tableData, 16'h0000, errNone);
  addCase("alloc second", opAlloc, 0, 0, 16'h0000, tableData, 16'h0001, errNone);
  addCase("alloc third", opAlloc, 0, 0, 16'h0000, tableData, 16'h0002, errNone);
  addCase("write a0 i2", opWrite, 0, 2, 16'h1234, errorOnly, 16'h0000, errNone);
  addCase("size a0 grown", opSize, 0, 0, 16'h0000, tableData, 16'h0003, errNone);
  addCase("read a0 i2", opRead, 0, 2, 16'h0000, tableData, 16'h1234, errNone);
  addCase("read past size", opRead, 0, 3, 16'h0000, errorOnly, 16'h0000, errOutOfBounds);
  addCase("pop empty a1", opPop, 1, 0, 16'h0000, errorOnly, 16'h0000, errEmpty);
  addCase("push a1 first", opPush, 1, 0, 16'h0011, errorOnly, 16'h0000, errNone);
  addCase("push a1 second", opPush, 1, 0, 16'h0022, errorOnly, 16'h0000, errNone);
  addCase("pop a1 last in", opPop, 1, 0, 16'h0000, tableData, 16'h0022, errNone);
  addCase("pop a1 first in", opPop, 1, 0, 16'h0000, tableData, 16'h0011, errNone);
  addCase("write a2 i7", opWrite, 2, 7, 16'h7777, errorOnly, 16'h0000, errNone);
  addCase("size a2 full", opSize, 2, 0, 16'h0000, tableData, 16'h0008, errNone);
  addCase("push full a2", opPush, 2, 0, 16'h0001, errorOnly, 16'h0000, errFull);
  // ------------------------------------------------------------------------
  // Read-modify-write on a0 i2 checked against the model
  // ------------------------------------------------------------------------
  addCase("add", opAdd, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("read after add", opRead, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("add after", opAddAfter, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("subtract", opSubtract, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("shift left", opShiftLeft, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("shift right", opShiftRight, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("read after shifts", opRead, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("not", opNot, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("or", opOr, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("xor", opXor, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("and", opAnd, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("read after logic", opRead, 0, 2, 16'h0000, modelData, 16'h0000, errNone);
  addCase("add past size", opAdd, 0, 5, 16'h0000, errorOnly, 16'h0000, errOutOfBounds);
  // ------------------------------------------------------------------------
  // Free, recycling, exhaustion and clear
  // ------------------------------------------------------------------------
  addCase("free a1", opFree, 1, 0, 16'h0000, errorOnly, 16'h0000, errNone);
  addCase("free a1 again", opFree, 1, 0, 16'h0000, errorOnly, 16'h0000, errNotAllocated);
  addCase("add on freed a1", opAdd, 1, 0, 16'h0000, errorOnly, 16'h0000, errNotAllocated);
  addCase("write on freed a1", opWrite, 1, 0, 16'hdead, errorOnly, 16'h0000, errNotAllocated);
  addCase("free a2", opFree, 2, 0, 16'h0000, errorOnly, 16'h0000, errNone);
  addCase("alloc recycled a2", opAlloc, 0, 0, 16'h0000, tableData, 16'h0002, errNone);
  addCase("alloc recycled a1", opAlloc, 0, 0, 16'h0000, tableData, 16'h0001, errNone);
  addCase("size recycled a1", opSize, 1, 0, 16'h0000, tableData, 16'h0000, errNone);
  addCase("write a1 i1", opWrite, 1, 1, 16'h0101, errorOnly, 16'h0000, errNone);
  addCase("read a1 i0 kept", opRead, 1, 0, 16'h0000, tableData, 16'h0011, errNone);
  addCase("alloc fourth", opAlloc, 0, 0, 16'h0000, tableData, 16'h0003, errNone);
  addCase("alloc fifth", opAlloc, 0, 0, 16'h0000, tableData, 16'h0004, errNone);
  addCase("alloc sixth", opAlloc, 0, 0, 16'h0000, tableData, 16'h0005, errNone);
  addCase("alloc seventh", opAlloc, 0, 0, 16'h0000, tableData, 16'h0006, errNone);
  addCase("alloc eighth", opAlloc, 0, 0, 16'h0000, tableData, 16'h0007, errNone);
  addCase("alloc exhausted", opAlloc, 0, 0, 16'h0000, errorOnly, 16'h0000, errOutOfMemory);
  addCase("clear", opClear, 0, 0, 16'h0000, errorOnly, 16'h0000, errNone);
  addCase("alloc after clear", opAlloc, 0, 0, 16'h0000, tableData, 16'h0000, errNone);
endtask

//--- bench/heapBench.sv
/*
  Testbench of the array heap behind its APB port.
  Runs the case table through APB transfers and checks every response
  against expected values and a reference model of elements and sizes.
*/
`timescale 1ns/100ps
`include "heap_settings.svh"

module heapBench;
  import heapPkg::*;

  localparam int transferTimeout = 10;                   // Cycles allowed per transfer

  typedef enum logic [1:0] {errorOnly, tableData, modelData} checkKind;

  typedef struct packed {
    heapOpcode   opcode;
    arrayNumber  array;
    elementIndex index;
    heapData     operand;                                // Replaced for arithmetic rows
    checkKind    check;
    heapData     expData;
    heapError    expError;
  } caseRow;

  logic       clock = 1'b0;
  logic       resetN;
  apbRequest  request;
  apbResponse response;

  string      caseNames [$];
  caseRow     caseRows [$];
  heapData    modelElements [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  arraySize   modelSizes [`HEAP_ARRAYS];
  int         seed = 32'h29ed;
  int         checks = 0;
  int         failures = 0;

  heapTop dut (
    .clock    (clock),
    .resetN   (resetN),
    .request  (request),
    .response (response)
  );

  always #10 clock = ~clock;                             // 20 ns period

  task automatic addCase(input string name, input heapOpcode opcode, input arrayNumber array,
                         input elementIndex index, input heapData operand,
                         input checkKind check, input heapData expData,
                         input heapError expError);
    caseNames.push_back(name);
    caseRows.push_back({opcode, array, index, operand, check, expData, expError});
  endtask

  `include "heapCases.svh"

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic checkData(input string name, input heapData expected, input heapData actual);
    checks++;
    if (actual !== expected) begin
      failures++;
      $display("Error %s data expected 0x%h actual 0x%h", name, expected, actual);
    end else begin
      $display("ok    %s data 0x%h", name, actual);
    end
  endtask

  task automatic checkError(input string name, input heapError expected, input heapError actual);
    checks++;
    if (actual !== expected) begin
      failures++;
      $display("Error %s error expected %s actual %s", name, expected.name(), actual.name());
    end else begin
      $display("ok    %s error %s", name, actual.name());
    end
  endtask

  task automatic verifyFlag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      failures++;
      $display("Error %s expected %b actual %b", name, expected, actual);
    end else begin
      $display("ok    %s %b", name, actual);
    end
  endtask

  // --------------------------------------------------------------------------
  // APB transfer, called 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic apbTransfer(input caseRow row, input heapData operand, output heapData data,
                             output heapError err, output int cycles, output logic timedOut);
    request.psel         = 1'b1;                         // Setup phase
    request.penable      = 1'b0;
    request.paddr.opcode = row.opcode;
    request.paddr.array  = row.array;
    request.paddr.index  = row.index;
    request.pwdata       = operand;
    cycles               = 1;
    timedOut             = 1'b0;
    @(posedge clock);
    #1;
    request.penable = 1'b1;                              // Access phase
    cycles          = 2;
    while (!response.pready && !timedOut) begin
      if (cycles >= transferTimeout) begin
        timedOut = 1'b1;
      end else begin
        @(posedge clock);
        #1;
        cycles++;
      end
    end
    data = response.prdata;
    err  = response.pslverr ? heapError'(response.prdata[3:0]) : errNone;
    @(posedge clock);
    #1;
    request.psel    = 1'b0;
    request.penable = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Reference model of elements and sizes
  // --------------------------------------------------------------------------
  task automatic modelStep(input caseRow row, input heapData operand, output heapData expected);
    arraySize    size;
    elementIndex slot;
    heapData     old;
    heapData     updated;
    size = modelSizes[row.array];
    slot = row.index;
    if (row.opcode == opPush) slot = elementIndex'(size);
    if (row.opcode == opPop) slot = elementIndex'(size - 1'b1);
    old = modelElements[row.array][slot];
    case (row.opcode)
      opWrite, opPush:   updated = operand;
      opAdd, opAddAfter: updated = old + operand;
      opSubtract:        updated = old - operand;
      opShiftLeft:       updated = old << operand;
      opShiftRight:      updated = old >> operand;
      opNot:             updated = ~old;
      opOr:              updated = old | operand;
      opXor:             updated = old ^ operand;
      opAnd:             updated = old & operand;
      default:           updated = old;
    endcase
    case (row.opcode)
      opRead, opPop, opAddAfter: expected = old;         // Value before any change
      opSize:                    expected = heapData'(size);
      opClear, opAlloc, opFree:  expected = row.expData;
      default:                   expected = updated;
    endcase
    if (row.expError == errNone) begin
      modelElements[row.array][slot] = updated;
      case (row.opcode)
        opWrite: begin
          if ({1'b0, row.index} >= size) modelSizes[row.array] = {1'b0, row.index} + 1'b1;
        end
        opPush:  modelSizes[row.array] = size + 1'b1;
        opPop:   modelSizes[row.array] = size - 1'b1;
        opAlloc: modelSizes[arrayNumber'(row.expData)] = '0;    // Granted array starts empty
        default: ;
      endcase
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    caseRow   row;
    heapData  operand;
    heapData  data;
    heapData  expected;
    heapError err;
    int       cycles;
    logic     timedOut;
    resetN   = 1'b0;
    request  = '0;
    timedOut = 1'b0;
    loadCases();
    for (int a = 0; a < `HEAP_ARRAYS; a++) begin
      modelSizes[a] = '0;
    end
    repeat (2) @(posedge clock);
    #1;
    resetN = 1'b1;
    verifyFlag("pready after reset", 1'b0, response.pready);
    verifyFlag("pslverr after reset", 1'b0, response.pslverr);
    @(posedge clock);
    #1;
    for (int i = 0; i < caseRows.size() && !timedOut; i++) begin
      row     = caseRows[i];
      operand = row.operand;
      if (row.opcode inside {opAdd, opAddAfter, opSubtract, opShiftLeft, opShiftRight,
                             opNot, opOr, opXor, opAnd}) begin
        operand = heapData'($random(seed));
      end
      if (row.opcode inside {opShiftLeft, opShiftRight}) begin
        operand = operand & 16'h000f;                    // Shift within the word
      end
      apbTransfer(row, operand, data, err, cycles, timedOut);
      if (timedOut) begin
        failures++;
        $display("Timeout: %s saw no pready within %0d cycles", caseNames[i], transferTimeout);
      end else begin
        if (cycles != 3) begin
          failures++;
          $display("Error %s pready cycle expected 3 actual %0d", caseNames[i], cycles);
        end
        modelStep(row, operand, expected);
        if (row.check == tableData) expected = row.expData;
        checkError(caseNames[i], row.expError, err);
        if (row.check != errorOnly && row.expError == errNone) begin
          checkData(caseNames[i], expected, data);
        end
      end
    end
    $display("%0d checks run, %0d failed", checks, failures);
    if (failures == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+source
+incdir+bench
source/heapPkg.sv
source/elementAlu.sv
source/arrayAllocator.sv
source/arrayStore.sv
source/heapController.sv
source/heapTop.sv
bench/heapBench.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the heap testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module heapBench \
  -f project.f --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VheapBench > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "All checks passed" "$logFile"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- source/arrayAllocator.sv
/*
  Array allocator of the heap.
  Keeps the allocated bitmap, a stack of freed arrays and the next never-used
  array, and grants an array on Alloc with freed arrays reused first.
*/
`timescale 1ns/100ps
`include "heap_settings.svh"

module arrayAllocator (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::allocRequest allocReq,
  output heapPkg::allocResult  allocResp
);
  import heapPkg::*;

  logic [`HEAP_ARRAYS-1:0]     allocated;                // One bit per array
  arrayNumber                  freedStack [`HEAP_ARRAYS];
  logic [`HEAP_ADDRESS_BITS:0] freedTop;                 // Entries on the freed stack
  logic [`HEAP_ADDRESS_BITS:0] freshCount;               // Arrays ever handed out fresh
  arrayNumber                  topIndex;
  logic                        haveFreed;
  logic                        haveFresh;

  assign topIndex  = arrayNumber'(freedTop - 1'b1);
  assign haveFreed = freedTop != '0;
  assign haveFresh = freshCount < `HEAP_ARRAYS;          // Never-used arrays remain

  // --------------------------------------------------------------------------
  // Query side, combinational
  // --------------------------------------------------------------------------
  assign allocResp.granted     = haveFreed ? freedStack[topIndex]
                                           : arrayNumber'(freshCount);
  assign allocResp.outOfMemory = !haveFreed && !haveFresh;
  assign allocResp.isAllocated = allocated[allocReq.array];

  // --------------------------------------------------------------------------
  // Bookkeeping
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated  <= '0;
      freedTop   <= '0;
      freshCount <= '0;
    end else if (allocReq.clear) begin                   // Forget every array
      allocated  <= '0;
      freedTop   <= '0;
      freshCount <= '0;
    end else if (allocReq.alloc && !allocResp.outOfMemory) begin
      allocated[allocResp.granted] <= 1'b1;
      if (haveFreed) begin
        freedTop <= freedTop - 1'b1;                     // Recycle most recent free
      end else begin
        freshCount <= freshCount + 1'b1;
      end
    end else if (allocReq.free) begin
      allocated[allocReq.array] <= 1'b0;                 // A second free is refused
      freedTop                  <= freedTop + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (allocReq.free && !allocReq.clear && !allocReq.alloc) begin
      freedStack[arrayNumber'(freedTop)] <= allocReq.array;
    end
  end

  assert property (@(posedge clock) disable iff (!resetN)
    allocReq.free |-> freedTop < `HEAP_ARRAYS)
    else $error("Freed stack overflow");

  assert property (@(posedge clock) disable iff (!resetN)
    allocReq.free |-> allocated[allocReq.array])
    else $error("Free of an array that is not allocated");

endmodule

//--- source/arrayStore.sv
/*
  Element memory and per-array sizes of the heap.
  One registered element read and one element write per cycle; the size of
  the read array is available combinationally.
*/
`timescale 1ns/100ps
`include "heap_settings.svh"

module arrayStore (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::storeRequest storeReq,
  output heapPkg::storeResult  storeResp
);
  import heapPkg::*;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  heapData  memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];   // Fixed block per array
  arraySize sizes  [`HEAP_ARRAYS];                       // Current size of each array
  heapData  readDataQ;

  // Element read lands one cycle after its address
  always_ff @(posedge clock) begin
    readDataQ <= memory[storeReq.readArray][storeReq.readIndex];
  end

  always_ff @(posedge clock) begin
    if (storeReq.writeEnable) begin
      memory[storeReq.writeArray][storeReq.writeIndex] <= storeReq.writeData;
    end
  end

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;                                  // Every array starts empty
      end
    end else if (storeReq.sizeEnable) begin
      sizes[storeReq.writeArray] <= storeReq.newSize;
    end
  end

  assign storeResp.readData    = readDataQ;
  assign storeResp.currentSize = sizes[storeReq.readArray];

  // Controller must never grow an array past its block
  assert property (@(posedge clock) disable iff (!resetN)
    storeReq.sizeEnable |-> storeReq.newSize <= `HEAP_ARRAY_LENGTH)
    else $error("Array size written past the block length");

endmodule

//--- source/elementAlu.sv
/*
  Arithmetic and logic on one heap element.
  Gives the new element value of a read-modify-write; for Write and Push
  the operand passes through as the value to store.
*/
`timescale 1ns/100ps

module elementAlu (
  input  heapPkg::heapOpcode opcode,
  input  heapPkg::heapData   element,
  input  heapPkg::heapData   operand,
  output heapPkg::heapData   result
);
  import heapPkg::*;

  always_comb begin
    case (opcode)
      opAdd,
      opAddAfter:   result = element + operand;          // Same sum, caller picks reply
      opSubtract:   result = element - operand;
      opShiftLeft:  result = element << operand;
      opShiftRight: result = element >> operand;         // Logical shift
      opNot:        result = ~element;
      opOr:         result = element | operand;
      opXor:        result = element ^ operand;
      opAnd:        result = element & operand;
      default:      result = operand;                    // Plain store of the bus data
    endcase
  end

endmodule

//--- source/heapController.sv
/*
  APB slave front end of the heap.
  Decodes the command in paddr, checks the access rules, drives the allocator
  and the store, and answers every transfer with one wait state.
*/
`timescale 1ns/100ps
`include "heap_settings.svh"

module heapController (
  input  logic                 clock,
  input  logic                 resetN,
  input  heapPkg::apbRequest   request,
  output heapPkg::apbResponse  response,
  output heapPkg::allocRequest allocReq,
  input  heapPkg::allocResult  allocResp,
  output heapPkg::storeRequest storeReq,
  input  heapPkg::storeResult  storeResp
);
  import heapPkg::*;

  typedef enum logic [1:0] {stateIdle, stateCompute, stateRespond} controlState;

  controlState state;
  heapCommand  command;
  elementIndex position;                                 // Element touched by the command
  heapError    errorCode;
  heapData     aluResult;
  heapData     resultData;
  logic        needsElement;
  logic        commit;

  assign command = request.paddr;
  assign commit  = state == stateCompute && errorCode == errNone;

  elementAlu alu (
    .opcode  (command.opcode),
    .element (storeResp.readData),
    .operand (request.pwdata),
    .result  (aluResult)
  );

  // --------------------------------------------------------------------------
  // Decode and access rules
  // --------------------------------------------------------------------------
  always_comb begin
    position     = command.index;
    needsElement = 1'b0;
    case (command.opcode)
      opPush:  position = elementIndex'(storeResp.currentSize);          // Next free slot
      opPop:   position = elementIndex'(storeResp.currentSize - 1'b1);   // Top of stack
      opRead, opAdd, opAddAfter, opSubtract, opShiftLeft, opShiftRight,
      opNot, opOr, opXor, opAnd: needsElement = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    errorCode = errNone;
    if (command.opcode == opAlloc) begin
      if (allocResp.outOfMemory) errorCode = errOutOfMemory;
    end else if (command.opcode != opClear) begin
      if (!allocResp.isAllocated) begin
        errorCode = errNotAllocated;
      end else if (needsElement && {1'b0, command.index} >= storeResp.currentSize) begin
        errorCode = errOutOfBounds;
      end else if (command.opcode == opPush && storeResp.currentSize == `HEAP_ARRAY_LENGTH) begin
        errorCode = errFull;
      end else if (command.opcode == opPop && storeResp.currentSize == '0) begin
        errorCode = errEmpty;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Store and allocator actions, issued only in the compute cycle
  // --------------------------------------------------------------------------
  always_comb begin
    allocReq            = '0;
    allocReq.array      = command.array;
    storeReq            = '0;
    storeReq.readArray  = command.array;                 // Held through the whole transfer
    storeReq.readIndex  = position;
    storeReq.writeArray = command.array;
    storeReq.writeIndex = position;
    storeReq.writeData  = aluResult;
    resultData          = aluResult;
    case (command.opcode)
      opClear: allocReq.clear = commit;
      opAlloc: begin
        allocReq.alloc      = commit;
        storeReq.writeArray = allocResp.granted;         // Fresh array starts empty
        storeReq.sizeEnable = commit;
        resultData          = heapData'(allocResp.granted);
      end
      opFree: begin
        allocReq.free = commit;
        resultData    = '0;
      end
      opWrite: begin
        storeReq.writeEnable = commit;
        storeReq.sizeEnable  = commit && {1'b0, command.index} >= storeResp.currentSize;
        storeReq.newSize     = {1'b0, command.index} + 1'b1;
      end
      opRead:  resultData = storeResp.readData;
      opSize:  resultData = heapData'(storeResp.currentSize);
      opPush: begin
        storeReq.writeEnable = commit;
        storeReq.sizeEnable  = commit;
        storeReq.newSize     = storeResp.currentSize + 1'b1;
      end
      opPop: begin
        storeReq.sizeEnable = commit;
        storeReq.newSize    = storeResp.currentSize - 1'b1;
        resultData          = storeResp.readData;
      end
      opAddAfter: begin
        storeReq.writeEnable = commit;
        resultData           = storeResp.readData;       // Value before the add
      end
      default: storeReq.writeEnable = commit;            // Arithmetic and logic
    endcase
  end

  // --------------------------------------------------------------------------
  // APB state machine and registered response
  // --------------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state    <= stateIdle;
      response <= '0;
    end else begin
      case (state)
        stateIdle: begin
          if (request.psel && !request.penable) state <= stateCompute;   // Setup phase
        end
        stateCompute: begin
          state            <= stateRespond;
          response.pready  <= 1'b1;
          response.pslverr <= errorCode != errNone;
          response.prdata  <= errorCode != errNone ? heapData'(errorCode) : resultData;
        end
        stateRespond: begin
          state    <= stateIdle;
          response <= '0;
        end
        default: state <= stateIdle;
      endcase
    end
  end

  assert property (@(posedge clock) disable iff (!resetN)
    response.pready |-> request.psel && request.penable)
    else $error("pready high outside an access phase");

endmodule

//--- source/heapPkg.sv
/*
  Types shared by the heap modules and the testbench.
  Opcodes, error outcomes, element widths and the bundles between blocks.
*/
`include "heap_settings.svh"

package heapPkg;

  // --------------------------------------------------------------------------
  // Commands and outcomes
  // --------------------------------------------------------------------------
  typedef enum logic [`HEAP_OPCODE_BITS-1:0] {
    opClear      = 0,                                    // Release every array
    opAlloc      = 1,
    opFree       = 2,
    opWrite      = 3,
    opRead       = 4,
    opSize       = 5,
    opPush       = 6,
    opPop        = 7,
    opAdd        = 8,
    opAddAfter   = 9,                                    // Returns the old element
    opSubtract   = 10,
    opShiftLeft  = 11,
    opShiftRight = 12,
    opNot        = 13,                                   // Bitwise
    opOr         = 14,
    opXor        = 15,
    opAnd        = 16
  } heapOpcode;

  typedef enum logic [3:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errEmpty,
    errFull,
    errOutOfMemory
  } heapError;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayNumber;
  typedef logic [`HEAP_INDEX_BITS-1:0]   elementIndex;
  typedef logic [`HEAP_DATA_BITS-1:0]    heapData;
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize;      // One extra bit for a full array

  // --------------------------------------------------------------------------
  // Bundles
  // --------------------------------------------------------------------------
  typedef struct packed {
    heapOpcode   opcode;
    arrayNumber  array;
    elementIndex index;
  } heapCommand;                                         // Carried in paddr

  typedef struct packed {
    logic       psel;
    logic       penable;
    heapCommand paddr;
    heapData    pwdata;
  } apbRequest;

  typedef struct packed {
    heapData prdata;
    logic    pready;
    logic    pslverr;
  } apbResponse;

  typedef struct packed {
    logic       clear;
    logic       alloc;
    logic       free;
    arrayNumber array;                                   // Queried and freed array
  } allocRequest;

  typedef struct packed {
    arrayNumber granted;
    logic       outOfMemory;
    logic       isAllocated;                             // Refers to allocRequest.array
  } allocResult;

  typedef struct packed {
    arrayNumber  readArray;
    elementIndex readIndex;
    logic        writeEnable;
    arrayNumber  writeArray;                             // Also selects the size update
    elementIndex writeIndex;
    heapData     writeData;
    logic        sizeEnable;
    arraySize    newSize;
  } storeRequest;

  typedef struct packed {
    heapData  readData;                                  // One cycle after the read address
    arraySize currentSize;                               // Size of readArray
  } storeResult;

endpackage

//--- source/heapTop.sv
/*
  Top level of the array heap behind an APB slave port.
  Connects the controller to the allocator and the element store.
*/
`timescale 1ns/100ps

module heapTop (
  input  logic                clock,
  input  logic                resetN,
  input  heapPkg::apbRequest  request,
  output heapPkg::apbResponse response
);
  import heapPkg::*;

  allocRequest allocReq;
  allocResult  allocResp;
  storeRequest storeReq;
  storeResult  storeResp;

  heapController controller (
    .clock     (clock),
    .resetN    (resetN),
    .request   (request),
    .response  (response),
    .allocReq  (allocReq),
    .allocResp (allocResp),
    .storeReq  (storeReq),
    .storeResp (storeResp)
  );

  arrayAllocator allocator (
    .clock     (clock),
    .resetN    (resetN),
    .allocReq  (allocReq),
    .allocResp (allocResp)
  );

  arrayStore store (
    .clock     (clock),
    .resetN    (resetN),
    .storeReq  (storeReq),
    .storeResp (storeResp)
  );

endmodule

//--- source/heap_settings.svh
/*
  Geometry and bus widths of the array heap.
  Included by the package and by every module that sizes storage.
*/
`ifndef HEAP_SETTINGS_SVH
`define HEAP_SETTINGS_SVH

// ----------------------------------------------------------------------------
// Heap geometry
// ----------------------------------------------------------------------------
`define HEAP_ADDRESS_BITS 3                              // Bits of an array number
`define HEAP_INDEX_BITS   3                              // Bits of an element index
`define HEAP_DATA_BITS    16                             // Element width

`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)      // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)        // Elements per array

// ----------------------------------------------------------------------------
// Command encoding
// ----------------------------------------------------------------------------
`define HEAP_OPCODE_BITS  5                              // Opcode field of paddr

`endif
